// ==== source/pat_pkg.sv ====
`default_nettype none

package pat_pkg;

	// ============================================================
	// widths
	// ============================================================
	typedef logic [7:0]  data_t;   // acc, dmem word, io
	typedef logic [9:0]  iaddr_t;  // pc and branch target
	typedef logic [19:0] instr_t;  // full instruction word
	typedef logic [3:0]  opcode_t; // any of the three spaces
	typedef logic [1:0]  cond_t;   // 00 z, 01 n, else always
	typedef logic [3:0]  alu_op_t;

	// alu function select
	localparam alu_op_t alu_or     = 4'd0; // zero so an empty ctrl is harmless
	localparam alu_op_t alu_and    = 4'd1;
	localparam alu_op_t alu_add    = 4'd2;
	localparam alu_op_t alu_sub    = 4'd3;
	localparam alu_op_t alu_not    = 4'd4;
	localparam alu_op_t alu_shl    = 4'd5;
	localparam alu_op_t alu_shlo   = 4'd6;
	localparam alu_op_t alu_shr    = 4'd7;
	localparam alu_op_t alu_asr    = 4'd8;
	localparam alu_op_t alu_pass_b = 4'd9; // loads

	// ============================================================
	// opcodes
	// ============================================================
	localparam opcode_t opc_prefix = 4'b1111; // escape to next space

	// i8 space, bits 11..8
	localparam opcode_t opc_or   = 4'h0;
	localparam opcode_t opc_and  = 4'h1;
	localparam opcode_t opc_addm = 4'h2;
	localparam opcode_t opc_subm = 4'h3;
	localparam opcode_t opc_add  = 4'h4;
	localparam opcode_t opc_sub  = 4'h5;
	localparam opcode_t opc_ldi  = 4'h6;
	localparam opcode_t opc_ldm  = 4'h7;
	localparam opcode_t opc_bf   = 4'h8;
	localparam opcode_t opc_bb   = 4'h9;
	localparam opcode_t opc_stam = 4'hb;
	localparam opcode_t opc_orm  = 4'hd;
	localparam opcode_t opc_andm = 4'he;

	// i3 space, bits 7..4
	localparam opcode_t opc_shl  = 4'h0;
	localparam opcode_t opc_shlo = 4'h1;
	localparam opcode_t opc_shr  = 4'h2;
	localparam opcode_t opc_asr  = 4'h3;
	localparam opcode_t opc_in   = 4'h5;
	localparam opcode_t opc_out  = 4'h8;

	// i0 space, bits 3..0
	localparam opcode_t opc_not  = 4'h0;
	localparam opcode_t opc_test = 4'h2;
	localparam opcode_t opc_nop  = 4'hf;

	localparam instr_t instr_nop = 20'h06ff5; // bubble word

	// decoded controls, one instruction
	typedef struct packed {
		alu_op_t alu_op;
		cond_t   cond;
		logic    wr_acc;  // acc takes alu or inputs
		logic    sel_in;  // IN
		logic    wr_mem;  // STAM
		logic    do_out;  // OUT
		logic    do_test; // TEST, reload z/n
	} ctrl_t;

endpackage

`default_nettype wire

// ==== source/pat_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module pat_fetch import pat_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   i_jump,        // branch sitting in ir
	input  iaddr_t i_target,
	input  instr_t i_instruction, // word at o_pc
	output iaddr_t o_pc,
	output instr_t o_ir,
	output iaddr_t o_ir_pc        // where o_ir came from
);

	iaddr_t pc;
	instr_t ir;
	iaddr_t ir_pc;

	// ============================================================
	// pc and instruction register
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			ir <= instr_nop;
		end
		else if (i_jump)
		begin
			pc <= i_target;  // redirect
			ir <= instr_nop; // word behind the branch never runs
		end
		else
		begin
			pc <= pc + 1'b1; // wraps at 1024
			ir <= i_instruction;
		end
	end

	// address tag travels with the word, used for branch offsets
	always_ff @(posedge clk)
	begin
		ir_pc <= pc;
	end

	assign o_pc    = pc;
	assign o_ir    = ir;
	assign o_ir_pc = ir_pc;

endmodule

`default_nettype wire

// ==== source/pat_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module pat_decode import pat_pkg::*;
#(
	parameter int dmem_depth = 32
)
(
	input  logic   clk,
	input  logic   reset,
	input  instr_t i_ir,
	input  iaddr_t i_ir_pc,
	input  data_t  i_mem_rdata,
	output logic   o_jump,
	output iaddr_t o_target,
	output data_t  o_mem_raddr,
	output ctrl_t  o_ctrl,
	output data_t  o_operand,
	output data_t  o_waddr
);

	localparam int addr_w = $clog2(dmem_depth);
	localparam data_t addr_mask = data_t'((1 << addr_w) - 1);

	// ============================================================
	// fields
	// ============================================================
	cond_t   cond;
	opcode_t op_i8, op_i3, op_i0;
	data_t   imm8, imm3, maddr;
	logic    is_i8, is_i3, is_i0;
	logic    acc_i8, acc_i3, acc_i0;
	alu_op_t alu_i8, alu_i3;
	logic    src_mem;
	ctrl_t   ctrl;

	assign cond  = i_ir[14:13]; // 19..15 and 12 ignored
	assign op_i8 = i_ir[11:8];
	assign op_i3 = i_ir[7:4];
	assign op_i0 = i_ir[3:0];
	assign imm8  = i_ir[7:0];
	assign imm3  = {5'b0, i_ir[2:0]};
	assign maddr = imm8 & addr_mask; // wrap to dmem size

	assign is_i8 = (op_i8 != opc_prefix);
	assign is_i3 = !is_i8 && (op_i3 != opc_prefix);
	assign is_i0 = !is_i8 && !is_i3;

	// per space alu select, acc_* marks ops that write acc
	always_comb
	begin
		alu_i8 = alu_pass_b;
		acc_i8 = 1'b1;
		case (op_i8)
			opc_or, opc_orm:   alu_i8 = alu_or;
			opc_and, opc_andm: alu_i8 = alu_and;
			opc_add, opc_addm: alu_i8 = alu_add;
			opc_sub, opc_subm: alu_i8 = alu_sub;
			opc_ldi, opc_ldm:  alu_i8 = alu_pass_b;
			default:           acc_i8 = 1'b0; // branches, stam, dropped
		endcase
		alu_i3 = alu_pass_b;
		acc_i3 = 1'b1;
		case (op_i3)
			opc_shl:  alu_i3 = alu_shl;
			opc_shlo: alu_i3 = alu_shlo;
			opc_shr:  alu_i3 = alu_shr;
			opc_asr:  alu_i3 = alu_asr;
			opc_in:   alu_i3 = alu_pass_b; // mux in execute picks inputs
			default:  acc_i3 = 1'b0;
		endcase
		case (op_i0)
			opc_not: acc_i0 = 1'b1;
			opc_nop: acc_i0 = 1'b0; // idle word
			default: acc_i0 = 1'b0;
		endcase
	end

	assign src_mem = is_i8 && (op_i8 == opc_addm || op_i8 == opc_subm
		|| op_i8 == opc_ldm || op_i8 == opc_orm || op_i8 == opc_andm);

	// merge the three spaces, anything unknown stays all zero
	assign ctrl.wr_acc  = (is_i8 & acc_i8) | (is_i3 & acc_i3) | (is_i0 & acc_i0);
	assign ctrl.sel_in  = is_i3 && (op_i3 == opc_in);
	assign ctrl.wr_mem  = is_i8 && (op_i8 == opc_stam);
	assign ctrl.do_out  = is_i3 && (op_i3 == opc_out);
	assign ctrl.do_test = is_i0 && (op_i0 == opc_test);
	assign ctrl.alu_op  = !ctrl.wr_acc ? alu_or : is_i8 ? alu_i8 : is_i3 ? alu_i3 : alu_not;
	assign ctrl.cond    = (ctrl.wr_acc | ctrl.wr_mem | ctrl.do_out | ctrl.do_test) ? cond : '0;

	// branches resolve here, one bubble behind them
	assign o_jump   = is_i8 && (op_i8 == opc_bf || op_i8 == opc_bb);
	assign o_target = (op_i8 == opc_bb) ? i_ir_pc - iaddr_t'(imm8) : i_ir_pc + iaddr_t'(imm8);
	assign o_mem_raddr = maddr;

	// ============================================================
	// stage register into execute
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			o_ctrl <= '0; // nothing pending
		else
			o_ctrl <= ctrl;
	end

	always_ff @(posedge clk)
	begin
		o_operand <= src_mem ? i_mem_rdata : (is_i8 ? imm8 : imm3);
		o_waddr   <= maddr; // store target
	end

endmodule

`default_nettype wire

// ==== source/pat_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module pat_alu import pat_pkg::*;
(
	input  data_t   i_a,  // accumulator
	input  data_t   i_b,  // operand, imm or mem
	input  alu_op_t i_op,
	output data_t   o_y
);

	logic [2:0] sh; // shift distance
	data_t      ones_fill;

	assign sh = i_b[2:0];

	// low sh bits set, for shlo
	assign ones_fill = ~(8'hff << sh);

	always_comb
	begin
		case (i_op)
			alu_or:     o_y = i_a | i_b;
			alu_and:    o_y = i_a & i_b;
			alu_add:    o_y = i_a + i_b;
			alu_sub:    o_y = i_a - i_b;
			alu_not:    o_y = ~i_a;
			alu_shl:    o_y = i_a << sh;
			alu_shlo:   o_y = (i_a << sh) | ones_fill; // shift in ones
			alu_shr:    o_y = i_a >> sh;
			alu_asr:    o_y = data_t'($signed(i_a) >>> sh); // sign kept
			alu_pass_b: o_y = i_b; // ldi, ldm
			default:    o_y = i_b;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/pat_data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module pat_data_mem import pat_pkg::*;
#(
	parameter int dmem_depth = 32
)
(
	input  logic  clk,
	input  data_t i_raddr,
	input  data_t i_waddr,
	input  logic  i_we,
	input  data_t i_wdata,
	output data_t o_rdata
);

	localparam int addr_w = $clog2(dmem_depth);

	data_t mem [dmem_depth]; // contents undefined until written

	// async read, old value during a same cycle write
	assign o_rdata = mem[i_raddr[addr_w-1:0]];

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_waddr[addr_w-1:0]] <= i_wdata; // upper bits dropped
	end

endmodule

`default_nettype wire

// ==== source/pat_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module pat_execute import pat_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  ctrl_t i_ctrl,
	input  data_t i_operand,
	input  data_t i_waddr,
	input  data_t i_inputs,
	output data_t o_acc,
	output data_t o_outputs,
	output logic  o_mem_we,
	output data_t o_mem_waddr,
	output data_t o_mem_wdata
);

	data_t acc;
	data_t outputs;
	logic  z, n;   // flags, only TEST updates them
	logic  commit; // condition holds
	data_t alu_y;

	pat_alu u_alu
	(
		.i_a  (acc),
		.i_b  (i_operand),
		.i_op (i_ctrl.alu_op),
		.o_y  (alu_y)
	);

	// ============================================================
	// condition check
	// ============================================================
	always_comb
	begin
		case (i_ctrl.cond)
			2'b00:   commit = z;
			2'b01:   commit = n;
			default: commit = 1'b1; // 10, 11 always
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc     <= '0;
			outputs <= '0;
			z       <= 1'b0;
			n       <= 1'b0;
		end
		else if (commit)
		begin
			if (i_ctrl.wr_acc)
				acc <= i_ctrl.sel_in ? i_inputs : alu_y;
			if (i_ctrl.do_test)
			begin
				z <= (acc == '0);
				n <= acc[7]; // sign bit
			end
			if (i_ctrl.do_out)
				outputs <= acc;
		end
	end

	// store lands at the commit edge
	assign o_mem_we    = commit & i_ctrl.wr_mem;
	assign o_mem_waddr = i_waddr;
	assign o_mem_wdata = acc;

	assign o_acc     = acc;
	assign o_outputs = outputs;

endmodule

`default_nettype wire

// ==== source/pat_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module pat_core import pat_pkg::*;
#(
	parameter int dmem_depth = 32
)
(
	input  logic   clk,
	input  logic   reset,
	input  instr_t i_instruction,
	input  data_t  i_inputs,
	output iaddr_t o_pc,
	output logic   o_jump,
	output data_t  o_acc,
	output data_t  o_outputs
);

	instr_t ir;
	iaddr_t ir_pc;
	iaddr_t target;
	data_t  mem_raddr, mem_rdata;
	ctrl_t  ctrl;
	data_t  operand;
	data_t  waddr;
	logic   mem_we;
	data_t  mem_waddr, mem_wdata;

	// ============================================================
	// fetch -> decode -> execute
	// ============================================================
	pat_fetch u_fetch
	(
		.clk           (clk),
		.reset         (reset),
		.i_jump        (o_jump),
		.i_target      (target),
		.i_instruction (i_instruction),
		.o_pc          (o_pc),
		.o_ir          (ir),
		.o_ir_pc       (ir_pc)
	);

	pat_decode #(.dmem_depth(dmem_depth)) u_decode
	(
		.clk         (clk),
		.reset       (reset),
		.i_ir        (ir),
		.i_ir_pc     (ir_pc),
		.i_mem_rdata (mem_rdata),
		.o_jump      (o_jump),
		.o_target    (target),
		.o_mem_raddr (mem_raddr),
		.o_ctrl      (ctrl),
		.o_operand   (operand),
		.o_waddr     (waddr)
	);

	pat_data_mem #(.dmem_depth(dmem_depth)) u_dmem
	(
		.clk     (clk),
		.i_raddr (mem_raddr), // read in decode
		.i_waddr (mem_waddr), // write from execute
		.i_we    (mem_we),
		.i_wdata (mem_wdata),
		.o_rdata (mem_rdata)
	);

	pat_execute u_execute
	(
		.clk         (clk),
		.reset       (reset),
		.i_ctrl      (ctrl),
		.i_operand   (operand),
		.i_waddr     (waddr),
		.i_inputs    (i_inputs),
		.o_acc       (o_acc),
		.o_outputs   (o_outputs),
		.o_mem_we    (mem_we),
		.o_mem_waddr (mem_waddr),
		.o_mem_wdata (mem_wdata)
	);

endmodule

`default_nettype wire

// ==== sim/pat_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module pat_properties import pat_pkg::*;
(
	input logic   clk,
	input logic   reset,
	input instr_t i_instruction,
	input iaddr_t o_pc,
	input logic   o_jump
);

	int fail_count = 0; // failed assertions so far

	// pc_after is the branch address plus one
	function automatic iaddr_t expect_target(iaddr_t pc_after, instr_t w);
		iaddr_t base;
		base = pc_after - 1'b1;
		if (w[11:8] == opc_bb)
			return base - iaddr_t'(w[7:0]);
		return base + iaddr_t'(w[7:0]);
	endfunction

	// ============================================================
	// jump and pc rules
	// ============================================================
	assert property (@(posedge clk) disable iff (reset)
		!(o_jump && $past(o_jump)))
	else
	begin
		fail_count++;
		$error("o_jump high on two consecutive cycles");
	end

	assert property (@(posedge clk) disable iff (reset)
		(!$past(reset) && !$past(o_jump)) |-> (o_pc == $past(o_pc) + 1'b1))
	else
	begin
		fail_count++;
		$error("pc did not step by one");
	end

	// word seen two samples back is the branch itself
	assert property (@(posedge clk) disable iff (reset)
		(!$past(reset) && $past(o_jump))
		|-> (o_pc == expect_target($past(o_pc), $past(i_instruction, 2))))
	else
	begin
		fail_count++;
		$error("pc after branch is not the branch target");
	end

endmodule

bind pat_core pat_properties u_props
(
	.clk           (clk),
	.reset         (reset),
	.i_instruction (i_instruction),
	.o_pc          (o_pc),
	.o_jump        (o_jump)
);

`default_nettype wire

// ==== sim/pat_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module pat_clock_gen
(
	output logic o_clk,
	output logic o_reset
);

	initial
	begin
		o_clk = 1'b0;
		forever #20 o_clk = ~o_clk; // 40 ns period
	end

	// reset held for 5 rising edges, released on a falling edge
	initial
	begin
		o_reset = 1'b1;
		repeat (5) @(posedge o_clk);
		@(negedge o_clk);
		o_reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== sim/pat_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pat_tb import pat_pkg::*;
();

	localparam int n_slots = 200;          // fetch slots checked
	localparam int cycle_limit = n_slots + 50;

	logic   clk, reset;
	instr_t i_instruction;
	data_t  i_inputs;
	iaddr_t o_pc;
	logic   o_jump;
	data_t  o_acc, o_outputs;

	instr_t image [1024];
	data_t  in_seq [n_slots + 64]; // value present at each edge
	data_t  exp_acc [n_slots];
	data_t  exp_out [n_slots];
	integer seed = 32'he03c_16df;
	int     edges = 0;  // rising edges out of reset
	int     cycles = 0;
	int     rst_errs = 0, acc_errs = 0, out_errs = 0, prop_errs;

	pat_clock_gen u_clk (.o_clk(clk), .o_reset(reset));

	pat_core uut
	(
		.clk           (clk),
		.reset         (reset),
		.i_instruction (i_instruction),
		.i_inputs      (i_inputs),
		.o_pc          (o_pc),
		.o_jump        (o_jump),
		.o_acc         (o_acc),
		.o_outputs     (o_outputs)
	);

	// ============================================================
	// program image
	// ============================================================
	function automatic instr_t random_word();
		instr_t w;
		int     s;
		w = instr_t'($random(seed));
		s = $unsigned($random(seed)) % 8;
		if (s < 2)
		begin
			w[11:8] = opc_prefix; // i3 space
			case ($unsigned($random(seed)) % 6)
				0: w[7:4] = opc_shl;
				1: w[7:4] = opc_shlo;
				2: w[7:4] = opc_shr;
				3: w[7:4] = opc_asr;
				4: w[7:4] = opc_in;
				default: w[7:4] = opc_out;
			endcase
		end
		else if (s == 2)
		begin
			w[11:4] = 8'hff; // i0 space
			case ($unsigned($random(seed)) % 3)
				0: w[3:0] = opc_not;
				1: w[3:0] = opc_test;
				default: w[3:0] = opc_nop;
			endcase
		end
		else
		begin
			if (w[11:8] == opc_prefix)
				w[11:8] = opc_ldi;
			if (w[11:8] == opc_bf || w[11:8] == opc_bb)
			begin
				w[7:0] = data_t'(2 + $unsigned($random(seed)) % 8); // short hops
				if ($unsigned($random(seed)) % 4 != 0)
					w[11:8] = opc_bf; // mostly forward
			end
		end
		return w;
	endfunction

	task automatic build_program();
		opcode_t mem_ops [5];
		mem_ops = '{opc_ldm, opc_addm, opc_subm, opc_orm, opc_andm};
		for (int a = 0; a < 32; a++)
		begin
			// fill every memory word before anything loads it
			image[2*a]   = {5'b0, 2'b10, 1'b0, opc_ldi, data_t'($random(seed))};
			image[2*a+1] = {5'b0, 2'b10, 1'b0, opc_stam, data_t'(a)};
		end
		// store, one spacer, then a memory op on the same word
		for (int k = 0; k < 5; k++)
		begin
			image[64+3*k]   = {5'b0, 2'b10, 1'b0, opc_stam, data_t'(5*k+3)};
			image[64+3*k+1] = {5'b0, 2'b10, 1'b0, opc_add, data_t'($random(seed))};
			image[64+3*k+2] = {5'b0, 2'b10, 1'b0, mem_ops[k], data_t'(5*k+3)};
		end
		for (int a = 79; a < 1024; a++)
			image[a] = random_word();
		for (int i = 0; i < n_slots + 64; i++)
			in_seq[i] = data_t'($random(seed));
	endtask

	// ============================================================
	// reference model, one fetch slot per cycle
	// ============================================================
	task automatic run_model();
		iaddr_t     pc, next_pc;
		data_t      acc, outv, b, imm, pd;
		data_t      mem [32];
		logic       z, n, ok, squash, jump, we_now, pw;
		logic [4:0] ma, pa;
		logic [2:0] sh;
		instr_t     w;
		pc = '0;
		acc = '0;
		outv = '0;
		z = 1'b0;
		n = 1'b0;
		squash = 1'b0;
		pw = 1'b0;
		pa = '0;
		pd = '0;
		for (int i = 0; i < 32; i++)
			mem[i] = '0;
		for (int t = 0; t < n_slots; t++)
		begin
			w = squash ? instr_nop : image[pc]; // word behind a branch dies
			ok = (w[14:13] == 2'b00) ? z : (w[14:13] == 2'b01) ? n : 1'b1;
			imm = w[7:0];
			ma = imm[4:0];
			sh = w[2:0];
			b = mem[ma]; // misses the store one slot ahead
			next_pc = pc + 1'b1;
			jump = 1'b0;
			we_now = 1'b0;
			if (w[11:8] != opc_prefix)
			begin
				case (w[11:8])
					opc_or:   if (ok) acc = acc | imm;
					opc_and:  if (ok) acc = acc & imm;
					opc_add:  if (ok) acc = acc + imm;
					opc_sub:  if (ok) acc = acc - imm;
					opc_ldi:  if (ok) acc = imm;
					opc_addm: if (ok) acc = acc + b;
					opc_subm: if (ok) acc = acc - b;
					opc_ldm:  if (ok) acc = b;
					opc_orm:  if (ok) acc = acc | b;
					opc_andm: if (ok) acc = acc & b;
					opc_stam: we_now = ok;
					opc_bf:
					begin
						jump = 1'b1;
						next_pc = pc + iaddr_t'(imm);
					end
					opc_bb:
					begin
						jump = 1'b1;
						next_pc = pc - iaddr_t'(imm);
					end
					default: ;
				endcase
			end
			else if (w[7:4] != opc_prefix)
			begin
				case (w[7:4])
					opc_shl:  if (ok) acc = acc << sh;
					opc_shlo: if (ok) acc = (acc << sh) | data_t'((9'd1 << sh) - 1'b1);
					opc_shr:  if (ok) acc = acc >> sh;
					opc_asr:  if (ok) acc = data_t'({{8{acc[7]}}, acc} >> sh);
					opc_in:   if (ok) acc = in_seq[t+3]; // value at its commit edge
					opc_out:  if (ok) outv = acc;
					default: ;
				endcase
			end
			else if (ok && w[3:0] == opc_not)
				acc = ~acc;
			else if (ok && w[3:0] == opc_test)
			begin
				z = (acc == '0);
				n = acc[7];
			end
			if (pw)
				mem[pa] = pd; // previous slot's store lands now
			pw = we_now;
			pa = ma;
			pd = acc;
			exp_acc[t] = acc;
			exp_out[t] = outv;
			if (squash)
				squash = 1'b0; // pc already holds the target
			else
			begin
				pc = next_pc;
				squash = jump;
			end
		end
	endtask

	// ============================================================
	// stimulus and checks on the falling edge
	// ============================================================
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (!reset)
			edges <= edges + 1;
	end

	always @(negedge clk)
	begin
		i_instruction <= image[o_pc];
		i_inputs <= in_seq[edges+1]; // seen at the next edge
		if (reset)
		begin
			assert (o_pc == '0 && !o_jump && o_acc == '0 && o_outputs == '0)
			else
			begin
				rst_errs++;
				$display("[ERROR] reset: expected pc 0 jump 0 acc 00 out 00, got %0d %b %h %h",
					o_pc, o_jump, o_acc, o_outputs);
			end
		end
		else if (edges >= 3 && edges - 3 < n_slots)
		begin
			assert (o_acc == exp_acc[edges-3])
			else
			begin
				acc_errs++;
				$display("[ERROR] acc slot %0d: expected %h, actual %h",
					edges - 3, exp_acc[edges-3], o_acc);
			end
			assert (o_outputs == exp_out[edges-3])
			else
			begin
				out_errs++;
				$display("[ERROR] outputs slot %0d: expected %h, actual %h",
					edges - 3, exp_out[edges-3], o_outputs);
			end
		end
	end

	always @(posedge clk)
	begin
		if (cycles >= cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		i_instruction = instr_nop;
		i_inputs = '0;
		build_program();
		run_model();
		@(negedge reset);
		while (edges < n_slots + 3)
			@(negedge clk);
		@(negedge clk);
		prop_errs = uut.u_props.fail_count;
		$display("errors: reset %0d, acc %0d, outputs %0d, properties %0d",
			rst_errs, acc_errs, out_errs, prop_errs);
		if (rst_errs + acc_errs + out_errs + prop_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/pat_pkg.sv
source/pat_fetch.sv
source/pat_decode.sv
source/pat_alu.sv
source/pat_data_mem.sv
source/pat_execute.sv
source/pat_core.sv
sim/pat_properties.sv
sim/pat_clock_gen.sv
sim/pat_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the simulation, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pat_tb -f vlog.f -o pat_sim \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/pat_sim +verilator+error+limit+1000 > sim.log 2>&1

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
	|| { echo "no result line in sim.log"; exit 1; }
